// File: source/branch_pkg.sv
`default_nettype none

package branch_pkg;

  // address and table geometry
  localparam int ADDR_WIDTH     = 16;
  localparam int JUMP_BITS      = 4;
  localparam int BLT_INDEX_BITS = 4;
  localparam int BLT_ENTRIES    = 1 << BLT_INDEX_BITS;
  localparam int BLT_TAG_BITS   = ADDR_WIDTH - BLT_INDEX_BITS;

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [BLT_INDEX_BITS-1:0] blt_index_t;
  typedef logic [BLT_TAG_BITS-1:0]   blt_tag_t;

  // jump operation codes as decoded in the id stage
  typedef enum logic [JUMP_BITS-1:0] {
    JMP_OP_NOP = 4'h0,
    JMP_OP_J   = 4'h1,
    JMP_OP_JR  = 4'h2,
    JMP_OP_JEQ = 4'h3,
    JMP_OP_JNE = 4'h4,
    JMP_OP_JL  = 4'h5,
    JMP_OP_JLE = 4'h6,
    JMP_OP_JG  = 4'h7,
    JMP_OP_JGE = 4'h8,
    JMP_OP_JZ  = 4'h9,
    JMP_OP_JNZ = 4'ha
  } jop_t;

  typedef struct packed {
    logic zero;
    logic less;
    logic greater;
  } alu_flags_t;

  // branch instruction as seen in execute, with the prediction made at fetch
  typedef struct packed {
    jop_t  jop;
    addr_t pc;
    addr_t reg_address;
    addr_t imm_address;
    logic  pred_taken;
    addr_t pred_address;
  } ex_branch_t;

  // one bit per pipeline register to clear
  typedef struct packed {
    logic pc;
    logic if_id;
    logic id_ex;
    logic ex_mem;
  } flush_t;

  localparam flush_t FLUSH_NONE = 4'b0000;
  localparam flush_t FLUSH_ALL  = 4'b1111;

  typedef struct packed {
    logic     valid;
    blt_tag_t tag;
    addr_t    target;
  } blt_entry_t;

  typedef struct packed {
    addr_t key;
    addr_t val;
    logic  hit;
  } blt_write_t;

  // low address bits select the entry
  function automatic blt_index_t blt_index(input addr_t a);
    return a[BLT_INDEX_BITS-1:0];
  endfunction

  // high address bits are kept as tag
  function automatic blt_tag_t blt_tag(input addr_t a);
    return a[ADDR_WIDTH-1:BLT_INDEX_BITS];
  endfunction

endpackage

`default_nettype wire

// File: source/blt.sv
`timescale 1ns/100ps
`default_nettype none

// direct mapped branch lookup table
// read is combinational on the fetch pc, write lands at the clock edge
module blt
  import branch_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,

  input  wire blt_write_t wr,
  input  wire             write_en,

  input  wire addr_t      read_key,
  output addr_t           read_val,
  output logic            read_valid
);

  blt_entry_t entries [BLT_ENTRIES];
  blt_entry_t rd_entry;
  blt_index_t wr_index;

  assign wr_index = blt_index(wr.key);

  // reset invalidates every entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < BLT_ENTRIES; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (write_en) begin
      // a not-taken resolution drops the entry
      entries[wr_index] <= '{valid: wr.hit, tag: blt_tag(wr.key), target: wr.val};
    end
  end

  // same index read and written in one cycle sees the old entry
  assign rd_entry = entries[blt_index(read_key)];

  always_comb begin
    read_valid = rd_entry.valid && (rd_entry.tag == blt_tag(read_key));
    read_val   = rd_entry.target;
  end

  // a learned branch is visible for its key on the next cycle
  property p_write_visible;
    @(posedge clk) disable iff (!rst_n)
      (write_en && wr.hit)
      |=> entries[blt_index($past(wr.key))] ==
          blt_entry_t'{valid: 1'b1, tag: blt_tag($past(wr.key)), target: $past(wr.val)};
  endproperty

  a_write_visible: assert property (p_write_visible)
    else $error("blt: written entry not readable on the next cycle");

endmodule

`default_nettype wire

// File: source/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

// resolves the branch in execute against the alu flags
// and the fetch prediction that travelled with it
module branch_unit
  import branch_pkg::*;
(
  // clk and rst_n only feed the assertions
  input  wire             clk,
  input  wire             rst_n,

  input  wire ex_branch_t ex,
  input  wire alu_flags_t flags,

  output flush_t          flush,
  output addr_t           jump_address,

  output blt_write_t      blt_wr,
  output logic            blt_write_en
);

  typedef enum logic [1:0] {
    CLS_NONE,
    CLS_COND,
    CLS_JR
  } branch_class_t;

  branch_class_t br_class;
  logic          cond;
  logic          jr_predicted_ok;
  logic          mispredict;

  // condition decoder gives false for anything not conditional
  always_comb begin
    case (ex.jop)
      JMP_OP_JEQ, JMP_OP_JZ:  cond = flags.zero;
      JMP_OP_JNE, JMP_OP_JNZ: cond = !flags.zero;
      JMP_OP_JL:              cond = flags.less;
      JMP_OP_JLE:             cond = flags.less | flags.zero;
      JMP_OP_JG:              cond = flags.greater;
      JMP_OP_JGE:             cond = flags.greater | flags.zero;
      default:                cond = 1'b0;
    endcase
  end

  // branch class decoder
  always_comb begin
    case (ex.jop)
      JMP_OP_NOP, JMP_OP_J: br_class = CLS_NONE;
      JMP_OP_JR:            br_class = CLS_JR;
      JMP_OP_JEQ, JMP_OP_JNE,
      JMP_OP_JL,  JMP_OP_JLE,
      JMP_OP_JG,  JMP_OP_JGE,
      JMP_OP_JZ,  JMP_OP_JNZ:
                            br_class = CLS_COND;
      default:              br_class = CLS_NONE;
    endcase
  end

  // register jump is only right if fetch guessed the exact target
  assign jr_predicted_ok = ex.pred_taken && (ex.pred_address == ex.reg_address);

  always_comb begin
    case (br_class)
      CLS_COND: mispredict = cond ^ ex.pred_taken;
      CLS_JR:   mispredict = !jr_predicted_ok;
      default:  mispredict = 1'b0;
    endcase
  end

  assign flush = mispredict ? FLUSH_ALL : FLUSH_NONE;

  // corrected fetch address
  always_comb begin
    if (br_class == CLS_JR) begin
      jump_address = ex.reg_address;
    end else if (!cond && ex.pred_taken) begin
      // predicted taken but falls through
      jump_address = ex.pc + 1'b1;
    end else begin
      jump_address = ex.imm_address;
    end
  end

  // train the table on every resolved conditional branch and JR
  assign blt_write_en = (br_class == CLS_COND) || (br_class == CLS_JR);

  always_comb begin
    blt_wr.key = ex.pc;
    blt_wr.val = jump_address;
    blt_wr.hit = cond || (br_class == CLS_JR);
  end

  // the table learned imm_address for this pc, so a correct taken
  // prediction must carry the same target down the pipe
  a_pred_target: assert property (
    @(posedge clk) disable iff (!rst_n)
      (br_class == CLS_COND && ex.pred_taken && cond)
      |-> ex.pred_address == ex.imm_address
  ) else $error("branch_unit: correct prediction with wrong target");

  a_flush_mask: assert property (
    @(posedge clk) disable iff (!rst_n)
      flush == FLUSH_NONE || flush == FLUSH_ALL
  ) else $error("branch_unit: partial flush mask");

endmodule

`default_nettype wire

// File: source/fetch_pc.sv
`timescale 1ns/100ps
`default_nettype none

// fetch program counter
// priority order is redirect, stall, prediction, sequential
module fetch_pc
  import branch_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,

  input  wire        stall,

  input  wire        redirect,
  input  wire addr_t redirect_address,

  input  wire        take_branch,
  input  wire addr_t branch_predict,

  output addr_t      pc
);

  addr_t pc_next;

  always_comb begin
    if (redirect) begin
      // a mispredict fix goes through even when stalled
      pc_next = redirect_address;
    end else if (stall) begin
      pc_next = pc;
    end else if (take_branch) begin
      pc_next = branch_predict;
    end else begin
      pc_next = pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  a_stall_holds: assert property (
    @(posedge clk) disable iff (!rst_n)
      (stall && !redirect) |=> $stable(pc)
  ) else $error("fetch_pc: pc moved during stall");

endmodule

`default_nettype wire

// File: source/branch_subsys.sv
`timescale 1ns/100ps
`default_nettype none

// branch resolution and prediction around the fetch pc
module branch_subsys
  import branch_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,

  input  wire             stall,
  input  wire alu_flags_t flags,
  input  wire ex_branch_t ex,

  output wire addr_t      pc,
  output wire             take_branch,
  output wire addr_t      branch_predict,

  output wire flush_t     flush,
  output wire addr_t      jump_address
);

  wire blt_write_t blt_wr;
  wire             blt_write_en;

  fetch_pc fetch_pc0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall            (stall),
    .redirect         (flush.pc),
    .redirect_address (jump_address),
    .take_branch      (take_branch),
    .branch_predict   (branch_predict),
    .pc               (pc)
  );

  branch_unit branch_unit0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex           (ex),
    .flags        (flags),
    .flush        (flush),
    .jump_address (jump_address),
    .blt_wr       (blt_wr),
    .blt_write_en (blt_write_en)
  );

  // prediction lookup on the current fetch pc
  blt blt0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr         (blt_wr),
    .write_en   (blt_write_en),
    .read_key   (pc),
    .read_val   (branch_predict),
    .read_valid (take_branch)
  );

endmodule

`default_nettype wire

// File: tb/tb_clk.sv
`timescale 1ns/100ps
`default_nettype none

// free running clock and a reset held low for the first cycles
module tb_clk (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    // release away from the active edge
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/tb_branch.sv
`timescale 1ns/100ps
`default_nettype none

module tb_branch
  import branch_pkg::*;
();

  localparam int RESET_TIMEOUT = 20;
  localparam int RANDOM_STEPS  = 300;

  // one step of stimulus with the expected response
  typedef struct packed {
    logic       stall;
    alu_flags_t flags;
    ex_branch_t ex;
    flush_t     flush;
    addr_t      jaddr;
    addr_t      pc_after;
    logic       take;
    addr_t      pred;
  } row_t;

  wire        clk;
  wire        rst_n;
  logic       stall;
  alu_flags_t flags;
  ex_branch_t ex;
  wire addr_t  pc;
  wire         take_branch;
  wire addr_t  branch_predict;
  wire flush_t flush;
  wire addr_t  jump_address;

  row_t  rows[$];
  string names[$];
  int    errors;
  int    checks;
  int    seed;

  // shadow of the lookup table and of the fetch pc
  bit    sh_valid [BLT_ENTRIES];
  addr_t sh_key [BLT_ENTRIES];
  addr_t sh_target [BLT_ENTRIES];
  addr_t m_pc;

  jop_t cond_ops [8] = '{JMP_OP_JEQ, JMP_OP_JNE, JMP_OP_JL, JMP_OP_JLE,
                         JMP_OP_JG, JMP_OP_JGE, JMP_OP_JZ, JMP_OP_JNZ};

  tb_clk clk_gen0 (.clk(clk), .rst_n(rst_n));

  branch_subsys dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall          (stall),
    .flags          (flags),
    .ex             (ex),
    .pc             (pc),
    .take_branch    (take_branch),
    .branch_predict (branch_predict),
    .flush          (flush),
    .jump_address   (jump_address)
  );

  task automatic check(input string name, input string what,
                       input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", name, what, expected, actual);
    end
  endtask

  function automatic bit is_cond(input jop_t op);
    return op inside {JMP_OP_JEQ, JMP_OP_JNE, JMP_OP_JL, JMP_OP_JLE,
                      JMP_OP_JG, JMP_OP_JGE, JMP_OP_JZ, JMP_OP_JNZ};
  endfunction

  function automatic bit cond_true(input jop_t op, input alu_flags_t f);
    bit c;
    c = 1'b0;
    if (op == JMP_OP_JEQ || op == JMP_OP_JZ) c = f.zero;
    if (op == JMP_OP_JNE || op == JMP_OP_JNZ) c = !f.zero;
    if (op == JMP_OP_JL) c = f.less;
    if (op == JMP_OP_JLE) c = f.less || f.zero;
    if (op == JMP_OP_JG) c = f.greater;
    if (op == JMP_OP_JGE) c = f.greater || f.zero;
    return c;
  endfunction

  // fills in the expected response and advances the shadow state by one edge
  task automatic model_step(inout row_t r);
    int idx;
    bit c;
    bit miss;
    idx = int'(m_pc % BLT_ENTRIES);
    r.take = sh_valid[idx] && (sh_key[idx] == m_pc);
    r.pred = sh_target[idx];
    c = cond_true(r.ex.jop, r.flags);
    if (is_cond(r.ex.jop)) begin
      miss = (c != r.ex.pred_taken);
    end else if (r.ex.jop == JMP_OP_JR) begin
      miss = !(r.ex.pred_taken && r.ex.pred_address == r.ex.reg_address);
    end else begin
      miss = 1'b0;
    end
    r.flush = miss ? FLUSH_ALL : FLUSH_NONE;
    if (r.ex.jop == JMP_OP_JR) r.jaddr = r.ex.reg_address;
    else if (!c && r.ex.pred_taken) r.jaddr = r.ex.pc + 16'd1;
    else r.jaddr = r.ex.imm_address;
    if (miss) r.pc_after = r.jaddr;
    else if (r.stall) r.pc_after = m_pc;
    else if (r.take) r.pc_after = r.pred;
    else r.pc_after = m_pc + 16'd1;
    // table learns at the same edge
    if (is_cond(r.ex.jop) || r.ex.jop == JMP_OP_JR) begin
      idx = int'(r.ex.pc % BLT_ENTRIES);
      sh_valid[idx]  = c || (r.ex.jop == JMP_OP_JR);
      sh_key[idx]    = r.ex.pc;
      sh_target[idx] = r.jaddr;
    end
    m_pc = r.pc_after;
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the next one
  task automatic apply_step(input string name, input row_t r);
    stall = r.stall;
    flags = r.flags;
    ex    = r.ex;
    @(negedge clk);
    check(name, "flush", r.flush, flush);
    check(name, "jump_address", r.jaddr, jump_address);
    check(name, "take_branch", r.take, take_branch);
    if (r.take) check(name, "branch_predict", r.pred, branch_predict);
    @(posedge clk);
    #1;
    check(name, "pc", r.pc_after, pc);
  endtask

  task automatic add_row(input string n, input bit st, input logic [2:0] fl, input jop_t op,
                         input addr_t epc, input addr_t ra, input addr_t ia, input bit pt,
                         input addr_t pa, input bit fa, input addr_t ja, input addr_t pca,
                         input bit tk, input addr_t pr);
    row_t r;
    r = '0;
    r.stall = st;
    r.flags = alu_flags_t'(fl);
    r.ex.jop = op;
    r.ex.pc = epc;
    r.ex.reg_address = ra;
    r.ex.imm_address = ia;
    r.ex.pred_taken = pt;
    r.ex.pred_address = pa;
    r.flush = fa ? FLUSH_ALL : FLUSH_NONE;
    r.jaddr = ja;
    r.pc_after = pca;
    r.take = tk;
    r.pred = pr;
    rows.push_back(r);
    names.push_back(n);
  endtask

  // flags are {zero, less, greater}; pc starts at 1 after reset release
  task automatic load_table();
    add_row("nop_step",       0, 3'b000, JMP_OP_NOP, 'h0, 'h0, 'h0, 0, 'h0, 0, 'h0, 'h2, 0, 'h0);
    add_row("nop_step2",      0, 3'b000, JMP_OP_NOP, 'h0, 'h0, 'h0, 0, 'h0, 0, 'h0, 'h3, 0, 'h0);
    add_row("j_no_flush",     0, 3'b000, JMP_OP_J, 'h3, 'h0, 'h400, 0, 'h0, 0, 'h400, 'h4, 0, 'h0);
    add_row("stall_hold",     1, 3'b000, JMP_OP_NOP, 'h0, 'h0, 'h0, 0, 'h0, 0, 'h0, 'h4, 0, 'h0);
    add_row("jr_stall_redir", 1, 3'b000, JMP_OP_JR, 'h10, 'h200, 'h0, 0, 'h0, 1, 'h200, 'h200, 0, 0);
    add_row("jr_correct",     0, 3'b000, JMP_OP_JR, 'h20, 'h300, 0, 1, 'h300, 0, 'h300, 'h201, 0, 0);
    add_row("jr_wrong_addr",  0, 3'b000, JMP_OP_JR, 'h30, 'h350, 0, 1, 'h340, 1, 'h350, 'h350, 0, 0);
    add_row("learn_taken",    0, 3'b100, JMP_OP_JEQ, 'h45, 0, 'h120, 0, 0, 1, 'h120, 'h120, 0, 0);
    add_row("steer_to_a",     0, 3'b000, JMP_OP_JR, 'h61, 'h45, 'h0, 0, 'h0, 1, 'h45, 'h45, 0, 0);
    add_row("predict_hit",    0, 3'b000, JMP_OP_NOP, 0, 0, 0, 0, 0, 0, 'h0, 'h120, 1, 'h120);
    add_row("untrain_a",      0, 3'b000, JMP_OP_JEQ, 'h45, 0, 'h120, 1, 'h120, 1, 'h46, 'h46, 0, 0);
    add_row("steer_again",    0, 3'b000, JMP_OP_JR, 'h62, 'h45, 'h0, 0, 'h0, 1, 'h45, 'h45, 0, 0);
    add_row("untrained_miss", 0, 3'b000, JMP_OP_NOP, 0, 0, 0, 0, 0, 0, 'h0, 'h46, 0, 'h0);
    add_row("learn_alias",    0, 3'b000, JMP_OP_JNE, 'h75, 0, 'h130, 1, 'h130, 0, 'h130, 'h47, 0, 0);
    add_row("steer_alias",    0, 3'b000, JMP_OP_JR, 'h63, 'h45, 'h0, 0, 'h0, 1, 'h45, 'h45, 0, 0);
    add_row("alias_miss",     0, 3'b000, JMP_OP_NOP, 0, 0, 0, 0, 0, 0, 'h0, 'h46, 0, 'h0);
  endtask

  initial begin
    row_t r;
    int   t;
    int   rnd;
    stall  = 1'b0;
    flags  = '0;
    ex     = '0;
    errors = 0;
    checks = 0;
    seed   = 36;
    for (int i = 0; i < BLT_ENTRIES; i++) begin
      sh_valid[i]  = 1'b0;
      sh_key[i]    = '0;
      sh_target[i] = '0;
    end
    @(posedge clk);
    #1;
    check("reset", "pc", 0, pc);
    check("reset", "take_branch", 0, take_branch);
    check("reset", "flush", FLUSH_NONE, flush);
    t = 0;
    while (!rst_n && t < RESET_TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (!rst_n) begin
      errors++;
      $display("ERROR: reset was not released within %0d cycles", RESET_TIMEOUT);
    end else begin
      // first edge after release already counted up once
      m_pc = 16'd1;
      check("reset_release", "pc", m_pc, pc);
      load_table();
      foreach (rows[i]) begin
        r = rows[i];
        model_step(r);
        apply_step(names[i], rows[i]);
      end
      // every conditional op against every flag pattern and both guesses
      for (int o = 0; o < 8; o++) begin
        for (int f = 0; f < 8; f++) begin
          for (int p = 0; p < 2; p++) begin
            r = '0;
            r.flags = alu_flags_t'(f[2:0]);
            r.ex.jop = cond_ops[o];
            r.ex.pc = addr_t'(256 + 16 * o + f);
            r.ex.imm_address = addr_t'(512 + 16 * o + f);
            r.ex.pred_taken = p[0];
            r.ex.pred_address = r.ex.imm_address;
            model_step(r);
            apply_step($sformatf("cond_%s_f%0d_p%0d", r.ex.jop.name(), f, p), r);
          end
        end
      end
      // small address range so tags collide and predictions fire
      for (int n = 0; n < RANDOM_STEPS; n++) begin
        r = '0;
        rnd = $random(seed);
        r.ex.jop = jop_t'(4'(rnd[7:4] % 11));
        r.stall = (rnd[11:8] == 4'd0);
        r.flags = alu_flags_t'(rnd[14:12]);
        r.ex.pred_taken = rnd[15];
        r.ex.pc = addr_t'(rnd[21:16]);
        rnd = $random(seed);
        r.ex.reg_address = addr_t'(rnd[5:0]);
        r.ex.imm_address = addr_t'(rnd[13:8]);
        if (is_cond(r.ex.jop)) r.ex.pred_address = r.ex.imm_address;
        else if (rnd[16]) r.ex.pred_address = r.ex.reg_address;
        else r.ex.pred_address = addr_t'(rnd[29:24]);
        model_step(r);
        apply_step($sformatf("rand_%0d", n), r);
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/branch_pkg.sv
source/blt.sv
source/branch_unit.sv
source/fetch_pc.sv
source/branch_subsys.sv
tb/tb_clk.sv
tb/tb_branch.sv

// File: Makefile
TOP = tb_branch
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ) -f tb.f

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "Simulation passed" sim.log || (echo "FAIL"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(OBJ) sim.log
